// ==== source/eth_frame_pkg.sv ====
// PAUSE frame format constants
package eth_frame_pkg;

    // Line framing
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam int PREAMBLE_LEN = 7;
    localparam logic [7:0] SFD_BYTE = 8'hD5;

    // MAC control header, transmitted most significant byte first
    localparam logic [47:0] PAUSE_DST_ADDR = 48'h0180_C200_0001;
    localparam logic [15:0] MAC_CONTROL_TYPE = 16'h8808;
    localparam logic [15:0] PAUSE_OPCODE = 16'h0001;

    // Zero fill up to the 60 byte minimum before the FCS
    localparam int PAD_LEN = 42;
    localparam int FCS_LEN = 4;

    // CRC-32, reflected form
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // Preamble, SFD, 60 bytes of frame and the FCS
    localparam int FRAME_LINE_LEN = 72;

    // Frame fields, in line order, as walked by the generator FSM
    localparam logic [3:0] S_IDLE = 4'd0;
    localparam logic [3:0] S_PREAMBLE = 4'd1;
    localparam logic [3:0] S_SFD = 4'd2;
    localparam logic [3:0] S_DST_ADDR = 4'd3;
    localparam logic [3:0] S_SRC_ADDR = 4'd4;
    localparam logic [3:0] S_TYPE = 4'd5;
    localparam logic [3:0] S_OPCODE = 4'd6;
    localparam logic [3:0] S_PAUSE_PARAM = 4'd7;
    localparam logic [3:0] S_PAD = 4'd8;

endpackage

// ==== source/flow_ctrl_pkg.sv ====
// Flow control thresholds and timing
package flow_ctrl_pkg;

    localparam int LEVEL_W = 8;

    // Hysteresis band on the receive FIFO fill level
    localparam logic [LEVEL_W-1:0] XOFF_THRESHOLD = 8'd192;
    localparam logic [LEVEL_W-1:0] XON_THRESHOLD = 8'd64;

    // Pause time carried by XOFF frames
    localparam logic [15:0] PAUSE_QUANTA = 16'h0100;

    // Repeat interval for XOFF while congested, from end of frame
    localparam int REFRESH_CYCLES = 400;
    localparam int REFRESH_W = $clog2(REFRESH_CYCLES + 1);

    // Minimum interframe gap in byte times
    localparam int IFG_CYCLES = 12;
    localparam int IFG_W = $clog2(IFG_CYCLES + 1);

endpackage

// ==== source/tx_byte_if.sv ====
// Byte stream from frame generator to FCS stage
interface tx_byte_if;

    logic [7:0] data;
    logic valid;
    // High from destination address through the last pad byte
    logic crc_cover;
    logic last;

    modport source (
        output data,
        output valid,
        output crc_cover,
        output last
    );

    modport sink (
        input data,
        input valid,
        input crc_cover,
        input last
    );

endinterface

// ==== source/flow_ctrl_scheduler.sv ====
// XOFF and XON scheduling
module flow_ctrl_scheduler
    import flow_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [LEVEL_W-1:0] fifo_level,
    input  logic               frame_complete,
    output logic               request,
    output logic [15:0]        pause_time,
    output logic               xoff_active
);

    logic paused;
    logic pending;
    logic [15:0] pending_time;
    logic busy;
    logic [IFG_W-1:0] gap_cnt;
    logic [REFRESH_W-1:0] refresh_cnt;

    logic xoff_dec;
    logic xon_dec;
    logic refresh_dec;
    logic decision;
    logic [15:0] decision_time;
    logic line_free;

    assign xoff_dec = !paused && (fifo_level >= XOFF_THRESHOLD);
    assign xon_dec = paused && (fifo_level <= XON_THRESHOLD);
    // Refresh only matters while the band has not been left downward
    assign refresh_dec = paused && !xon_dec && (refresh_cnt == REFRESH_W'(1));

    assign decision = xoff_dec || xon_dec || refresh_dec;
    assign decision_time = xon_dec ? 16'h0000 : PAUSE_QUANTA;

    assign line_free = !busy && !request && (gap_cnt == '0);

    assign xoff_active = paused;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            paused <= 1'b0;
            pending <= 1'b0;
            pending_time <= 16'h0000;
            request <= 1'b0;
            pause_time <= 16'h0000;
            busy <= 1'b0;
            gap_cnt <= '0;
            refresh_cnt <= '0;
        end else begin
            if (xoff_dec) begin
                paused <= 1'b1;
            end else if (xon_dec) begin
                paused <= 1'b0;
            end

            // Newest decision replaces one still waiting for the line
            request <= 1'b0;
            if ((decision || pending) && line_free) begin
                request <= 1'b1;
                pause_time <= decision ? decision_time : pending_time;
                pending <= 1'b0;
            end else if (decision) begin
                pending <= 1'b1;
                pending_time <= decision_time;
            end

            if (request) begin
                busy <= 1'b1;
            end else if (frame_complete) begin
                busy <= 1'b0;
            end

            if (frame_complete) begin
                gap_cnt <= IFG_W'(IFG_CYCLES);
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - IFG_W'(1);
            end

            // Restart the XOFF refresh interval at the end of each XOFF frame
            if (frame_complete && paused && (pause_time != 16'h0000)) begin
                refresh_cnt <= REFRESH_W'(REFRESH_CYCLES);
            end else if (!paused) begin
                refresh_cnt <= '0;
            end else if (refresh_cnt != '0) begin
                refresh_cnt <= refresh_cnt - REFRESH_W'(1);
            end
        end
    end

endmodule

// ==== source/pause_frame_gen.sv ====
// PAUSE frame generator
module pause_frame_gen
    import eth_frame_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        request,
    input  logic [15:0] pause_time,
    input  logic [47:0] local_mac,
    tx_byte_if.source   byte_out
);

    logic request_r;
    logic [15:0] pause_time_r;
    logic [47:0] local_mac_r;

    logic [3:0] state;
    logic [3:0] next_state;
    logic [5:0] cnt;
    logic [5:0] next_cnt;

    logic [7:0] next_data;
    logic next_valid;
    logic next_cover;
    logic next_last;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            request_r <= 1'b0;
            pause_time_r <= 16'h0000;
            local_mac_r <= 48'h0;
        end else begin
            request_r <= request;
            pause_time_r <= pause_time;
            local_mac_r <= local_mac;
        end
    end

    always_comb begin
        next_state = state;
        next_cnt = cnt + 6'd1;
        next_data = 8'h00;
        next_valid = 1'b1;
        next_cover = 1'b1;
        next_last = 1'b0;

        case (state)
            S_IDLE: begin
                next_valid = 1'b0;
                next_cover = 1'b0;
                next_cnt = 6'd0;
                if (request_r) begin
                    next_state = S_PREAMBLE;
                end
            end
            S_PREAMBLE: begin
                next_data = PREAMBLE_BYTE;
                next_cover = 1'b0;
                if (cnt == 6'(PREAMBLE_LEN - 1)) begin
                    next_state = S_SFD;
                    next_cnt = 6'd0;
                end
            end
            S_SFD: begin
                next_data = SFD_BYTE;
                next_cover = 1'b0;
                next_state = S_DST_ADDR;
                next_cnt = 6'd0;
            end
            // Multi-byte fields go out most significant byte first
            S_DST_ADDR: begin
                next_data = PAUSE_DST_ADDR[8 * (5 - cnt) +: 8];
                if (cnt == 6'd5) begin
                    next_state = S_SRC_ADDR;
                    next_cnt = 6'd0;
                end
            end
            S_SRC_ADDR: begin
                next_data = local_mac_r[8 * (5 - cnt) +: 8];
                if (cnt == 6'd5) begin
                    next_state = S_TYPE;
                    next_cnt = 6'd0;
                end
            end
            S_TYPE: begin
                next_data = MAC_CONTROL_TYPE[8 * (1 - cnt) +: 8];
                if (cnt == 6'd1) begin
                    next_state = S_OPCODE;
                    next_cnt = 6'd0;
                end
            end
            S_OPCODE: begin
                next_data = PAUSE_OPCODE[8 * (1 - cnt) +: 8];
                if (cnt == 6'd1) begin
                    next_state = S_PAUSE_PARAM;
                    next_cnt = 6'd0;
                end
            end
            S_PAUSE_PARAM: begin
                next_data = pause_time_r[8 * (1 - cnt) +: 8];
                if (cnt == 6'd1) begin
                    next_state = S_PAD;
                    next_cnt = 6'd0;
                end
            end
            S_PAD: begin
                if (cnt == 6'(PAD_LEN - 1)) begin
                    next_last = 1'b1;
                    next_state = S_IDLE;
                    next_cnt = 6'd0;
                end
            end
            default: begin
                next_valid = 1'b0;
                next_cover = 1'b0;
                next_state = S_IDLE;
                next_cnt = 6'd0;
            end
        endcase
    end

    // Bytes are registered, so the stream trails the state by one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            cnt <= 6'd0;
            byte_out.data <= 8'h00;
            byte_out.valid <= 1'b0;
            byte_out.crc_cover <= 1'b0;
            byte_out.last <= 1'b0;
        end else begin
            state <= next_state;
            cnt <= next_cnt;
            byte_out.data <= next_data;
            byte_out.valid <= next_valid;
            byte_out.crc_cover <= next_cover;
            byte_out.last <= next_last;
        end
    end

endmodule

// ==== source/crc32_fcs.sv ====
// CRC-32 and FCS append stage
module crc32_fcs
    import eth_frame_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    tx_byte_if.sink    byte_in,
    output logic [7:0] tx_data,
    output logic       tx_en,
    output logic       frame_complete
);

    logic [31:0] crc;
    logic fcs_active;
    logic [1:0] fcs_cnt;

    // One byte of the reflected CRC, LSB of the data first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0] data);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            crc <= CRC_INIT;
            fcs_active <= 1'b0;
            fcs_cnt <= 2'd0;
            tx_data <= 8'h00;
            tx_en <= 1'b0;
            frame_complete <= 1'b0;
        end else begin
            // Falling edge of tx_en
            frame_complete <= tx_en && !byte_in.valid && !fcs_active;

            if (byte_in.valid) begin
                tx_data <= byte_in.data;
                tx_en <= 1'b1;
                if (byte_in.crc_cover) begin
                    crc <= crc32_byte(crc, byte_in.data);
                end else begin
                    // Preamble and SFD restart the CRC
                    crc <= CRC_INIT;
                end
            end else if (fcs_active) begin
                tx_data <= ~crc[7:0];
                tx_en <= 1'b1;
                crc <= crc >> 8;
            end else begin
                tx_en <= 1'b0;
            end

            if (byte_in.valid && byte_in.last) begin
                fcs_active <= 1'b1;
                fcs_cnt <= 2'd0;
            end else if (fcs_active) begin
                fcs_cnt <= fcs_cnt + 2'd1;
                if (fcs_cnt == 2'(FCS_LEN - 1)) begin
                    fcs_active <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== source/pause_tx_top.sv ====
// PAUSE transmit top level
module pause_tx_top
    import flow_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [LEVEL_W-1:0] fifo_level,
    input  logic [47:0]        local_mac,
    output logic [7:0]         tx_data,
    output logic               tx_en,
    output logic               frame_complete,
    output logic               xoff_active
);

    logic request;
    logic [15:0] pause_time;

    tx_byte_if u_byte_if ();

    flow_ctrl_scheduler u_scheduler (
        .clk            (clk),
        .reset          (reset),
        .fifo_level     (fifo_level),
        .frame_complete (frame_complete),
        .request        (request),
        .pause_time     (pause_time),
        .xoff_active    (xoff_active)
    );

    pause_frame_gen u_frame_gen (
        .clk        (clk),
        .reset      (reset),
        .request    (request),
        .pause_time (pause_time),
        .local_mac  (local_mac),
        .byte_out   (u_byte_if.source)
    );

    crc32_fcs u_fcs (
        .clk            (clk),
        .reset          (reset),
        .byte_in        (u_byte_if.sink),
        .tx_data        (tx_data),
        .tx_en          (tx_en),
        .frame_complete (frame_complete)
    );

endmodule

// ==== test/pause_frame_checker.sv ====
// PAUSE frame capture and check
module pause_frame_checker
    import eth_frame_pkg::*;
    import flow_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [7:0]      tx_data,
    input  logic            tx_en,
    input  logic            frame_complete,
    input  logic [47:0]     local_mac,
    input  logic [8*16-1:0] test_name,
    output int              xoff_frames,
    output int              xon_frames,
    output logic            frame_error
);
    timeunit 1ns;
    timeprecision 1ps;

    // Byte offsets on the line
    localparam int DST_AT = PREAMBLE_LEN + 1;
    localparam int SRC_AT = DST_AT + 6;
    localparam int TYPE_AT = SRC_AT + 6;
    localparam int OPCODE_AT = TYPE_AT + 2;
    localparam int PARAM_AT = OPCODE_AT + 2;
    localparam int PAD_AT = PARAM_AT + 2;
    localparam int FCS_AT = PAD_AT + PAD_LEN;

    logic [7:0] frame_bytes [$];
    logic in_frame;
    int idle_cycles;

    task automatic check_value(input string what, input logic [47:0] expected,
                               input logic [47:0] actual);
        if (!frame_error) begin
            assert (actual === expected) else begin
                $display("[ERROR] %0s: %0s expected %0h actual %0h",
                         test_name, what, expected, actual);
                frame_error = 1'b1;
            end
        end
    endtask

    // Most significant byte goes first on the line
    task automatic check_field(input string what, input int at, input int len,
                               input logic [47:0] value);
        for (int i = 0; i < len; i++) begin
            check_value($sformatf("%0s byte %0d", what, i),
                        48'(value[8 * (len - 1 - i) +: 8]), 48'(frame_bytes[at + i]));
        end
    endtask

    function automatic logic [31:0] reverse32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31 - i];
        end
        return r;
    endfunction

    // Shift register in normal form, each byte entering LSB first
    function automatic logic [31:0] expected_fcs();
        logic [31:0] poly;
        logic [31:0] crc;
        logic feedback;
        poly = reverse32(CRC_POLY);
        crc = CRC_INIT;
        for (int n = DST_AT; n < FCS_AT; n++) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[31] ^ frame_bytes[n][b];
                crc = crc << 1;
                if (feedback) begin
                    crc = crc ^ poly;
                end
            end
        end
        return ~reverse32(crc);
    endfunction

    task automatic check_frame();
        logic [15:0] pause_time;
        logic [31:0] fcs;
        check_value("frame length", 48'(FRAME_LINE_LEN), 48'(frame_bytes.size()));
        if (frame_error) begin
            return;
        end
        for (int i = 0; i < PREAMBLE_LEN; i++) begin
            check_value("preamble", 48'(PREAMBLE_BYTE), 48'(frame_bytes[i]));
        end
        check_value("SFD", 48'(SFD_BYTE), 48'(frame_bytes[PREAMBLE_LEN]));
        check_field("destination", DST_AT, 6, PAUSE_DST_ADDR);
        check_field("source", SRC_AT, 6, local_mac);
        check_field("type", TYPE_AT, 2, 48'(MAC_CONTROL_TYPE));
        check_field("opcode", OPCODE_AT, 2, 48'(PAUSE_OPCODE));
        for (int i = PAD_AT; i < FCS_AT; i++) begin
            check_value($sformatf("pad byte %0d", i - PAD_AT), 48'h0, 48'(frame_bytes[i]));
        end
        fcs = expected_fcs();
        for (int i = 0; i < FCS_LEN; i++) begin
            check_value($sformatf("FCS byte %0d", i), 48'(fcs[8 * i +: 8]),
                        48'(frame_bytes[FCS_AT + i]));
        end
        pause_time = {frame_bytes[PARAM_AT], frame_bytes[PARAM_AT + 1]};
        if (pause_time == 16'h0000) begin
            xon_frames++;
            $display("%0s: XON frame, pause time %04h", test_name, pause_time);
        end else begin
            check_value("XOFF pause time", 48'(PAUSE_QUANTA), 48'(pause_time));
            xoff_frames++;
            $display("%0s: XOFF frame, pause time %04h", test_name, pause_time);
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            frame_bytes.delete();
            in_frame = 1'b0;
            idle_cycles = 0;
            xoff_frames = 0;
            xon_frames = 0;
            frame_error = 1'b0;
        end else begin
            // Pulse only in the first idle cycle after a burst
            check_value("frame_complete", 48'(in_frame && !tx_en), 48'(frame_complete));
            if (tx_en) begin
                if (!in_frame && (xoff_frames + xon_frames) > 0 && !frame_error) begin
                    assert (idle_cycles >= IFG_CYCLES) else begin
                        $display("[ERROR] %0s: idle cycles expected at least %0d actual %0d",
                                 test_name, IFG_CYCLES, idle_cycles);
                        frame_error = 1'b1;
                    end
                end
                frame_bytes.push_back(tx_data);
                in_frame = 1'b1;
            end else begin
                if (in_frame) begin
                    check_frame();
                    frame_bytes.delete();
                    in_frame = 1'b0;
                    idle_cycles = 0;
                end
                idle_cycles++;
            end
        end
    end

endmodule

// ==== test/pause_tx_tb.sv ====
// PAUSE transmit testbench
module pause_tx_tb
    import flow_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [8*16-1:0] name;
        logic [LEVEL_W-1:0] level;
        logic [15:0] hold;
        logic [7:0] xoff_min;
        logic [7:0] xon_count;
        logic xoff_active;
    } row_t;

    localparam int ROW_COUNT = 8;

    // Each row starts from the state the previous one left behind
    localparam row_t ROWS [ROW_COUNT] = '{
        '{"idle_low", 8'd10, 16'd50, 8'd0, 8'd0, 1'b0},
        '{"xoff_cross", XOFF_THRESHOLD, 16'd120, 8'd1, 8'd0, 1'b1},
        '{"xoff_refresh", XOFF_THRESHOLD + 8'd38, 16'(REFRESH_CYCLES + 200), 8'd1, 8'd0, 1'b1},
        '{"band_paused", 8'd128, 16'd100, 8'd0, 8'd0, 1'b1},
        '{"xon_fall", XON_THRESHOLD, 16'd120, 8'd0, 8'd1, 1'b0},
        '{"band_free", 8'd150, 16'd100, 8'd0, 8'd0, 1'b0},
        '{"spike_up", XOFF_THRESHOLD + 8'd50, 16'd3, 8'd0, 8'd0, 1'b1},
        '{"spike_down", 8'd20, 16'd250, 8'd1, 8'd1, 1'b0}
    };

    logic clk;
    logic reset;
    logic [LEVEL_W-1:0] fifo_level;
    logic [47:0] local_mac;
    logic [7:0] tx_data;
    logic tx_en;
    logic frame_complete;
    logic xoff_active;

    logic [8*16-1:0] test_name;
    int xoff_frames;
    int xon_frames;
    logic frame_error;
    int cycle_count = 0;
    int timeout_limit;

    always #50 clk = ~clk;

    pause_tx_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .fifo_level     (fifo_level),
        .local_mac      (local_mac),
        .tx_data        (tx_data),
        .tx_en          (tx_en),
        .frame_complete (frame_complete),
        .xoff_active    (xoff_active)
    );

    pause_frame_checker u_checker (
        .clk            (clk),
        .reset          (reset),
        .tx_data        (tx_data),
        .tx_en          (tx_en),
        .frame_complete (frame_complete),
        .local_mac      (local_mac),
        .test_name      (test_name),
        .xoff_frames    (xoff_frames),
        .xon_frames     (xon_frames),
        .frame_error    (frame_error)
    );

    task automatic stop_on_failure(input string reason);
        $display("Regression failed");
        $fatal(1, "%0s", reason);
    endtask

    initial begin
        wait (frame_error === 1'b1);
        stop_on_failure("Frame checker reported a failure");
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: run went past %0d cycles", timeout_limit);
            stop_on_failure("Run did not finish in time");
        end
    end

    initial begin
        int xoff_seen;
        int xon_seen;
        int xoff_total;
        int xon_total;
        clk = 1'b0;
        reset = 1'b1;
        fifo_level = '0;
        test_name = "reset";
        void'($urandom(20491));
        local_mac[47:32] = 16'($urandom);
        local_mac[31:0] = $urandom;
        timeout_limit = 0;
        foreach (ROWS[r]) begin
            timeout_limit += ROWS[r].hold + 200;
        end
        xoff_total = 0;
        xon_total = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < ROW_COUNT; r++) begin
            test_name = ROWS[r].name;
            @(negedge clk);
            fifo_level = ROWS[r].level;
            repeat (ROWS[r].hold) @(negedge clk);
            // Let a frame already on the line run out
            while (tx_en) begin
                @(negedge clk);
            end
            @(negedge clk);
            xoff_seen = xoff_frames - xoff_total;
            xon_seen = xon_frames - xon_total;
            assert (xoff_seen >= ROWS[r].xoff_min) else begin
                $display("[ERROR] %0s: XOFF frames expected at least %0d actual %0d",
                         test_name, ROWS[r].xoff_min, xoff_seen);
                stop_on_failure("Too few XOFF frames");
            end
            // No XOFF at all where none is expected
            assert (ROWS[r].xoff_min != 0 || xoff_seen == 0) else begin
                $display("[ERROR] %0s: XOFF frames expected 0 actual %0d", test_name, xoff_seen);
                stop_on_failure("Unexpected XOFF frame");
            end
            assert (xon_seen == ROWS[r].xon_count) else begin
                $display("[ERROR] %0s: XON frames expected %0d actual %0d",
                         test_name, ROWS[r].xon_count, xon_seen);
                stop_on_failure("Wrong number of XON frames");
            end
            assert (xoff_active === ROWS[r].xoff_active) else begin
                $display("[ERROR] %0s: xoff_active expected %0b actual %0b",
                         test_name, ROWS[r].xoff_active, xoff_active);
                stop_on_failure("Wrong paused state");
            end
            xoff_total = xoff_frames;
            xon_total = xon_frames;
        end

        if (!frame_error) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_on_failure("Frame checks failed");
        end
    end

endmodule

// ==== tb.f ====
source/eth_frame_pkg.sv
source/flow_ctrl_pkg.sv
source/tx_byte_if.sv
source/flow_ctrl_scheduler.sv
source/pause_frame_gen.sv
source/crc32_fcs.sv
source/pause_tx_top.sv
test/pause_frame_checker.sv
test/pause_tx_tb.sv

// ==== Bender.yml ====
package:
  name: pause_tx

dependencies: {}

sources:
  # Packages and the interface come before the modules that use them
  - files:
      - source/eth_frame_pkg.sv
      - source/flow_ctrl_pkg.sv
      - source/tx_byte_if.sv
      - source/flow_ctrl_scheduler.sv
      - source/pause_frame_gen.sv
      - source/crc32_fcs.sv
      - source/pause_tx_top.sv

  # Testbench, top module pause_tx_tb
  - target: test
    files:
      - test/pause_frame_checker.sv
      - test/pause_tx_tb.sv
